// File: tb.f
+incdir+testbench
design/fifo_pkg.sv
design/dual_port_ram.sv
design/register_synchronizer.sv
design/fifo_write_port.sv
design/fifo_read_port.sv
design/cross_clock_fifo.sv
testbench/tb_cross_clock_fifo.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_cross_clock_fifo \
	-f tb.f -o sim > build.log 2>&1 &&
./obj_dir/sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

// File: testbench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////
// Shared state

int error_count = 0;
string current_test = "";

// Expected FIFO contents, oldest first
fifo_data_t model_queue[$];

// Fibonacci LFSR register
logic [15:0] lfsr_state = 16'd66;

////////////////////
// Compare tasks

task automatic compare_data(input string what, input fifo_data_t expected,
		input fifo_data_t actual);
	if (actual !== expected) begin
		$display("mismatch in %s: %s expected %h actual %h",
			current_test, what, expected, actual);
		error_count++;
	end
endtask

task automatic compare_size(input string what, input fifo_ptr_t expected,
		input fifo_ptr_t actual);
	if (actual !== expected) begin
		$display("mismatch in %s: %s expected %0d actual %0d",
			current_test, what, expected, actual);
		error_count++;
	end
endtask

task automatic compare_flag(input string what, input logic expected, input logic actual);
	if (actual !== expected) begin
		$display("mismatch in %s: %s expected %b actual %b",
			current_test, what, expected, actual);
		error_count++;
	end
endtask

////////////////////
// Stimulus

// Taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
	return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

// One step per data bit, MSB first
function automatic fifo_data_t random_word();
	fifo_data_t word;
	word = '0;
	for (int i = 0; i < FIFO_WIDTH; i++) begin
		word = {word[FIFO_WIDTH-2:0], lfsr_state[15]};
		lfsr_state = lfsr_step(lfsr_state);
	end
	return word;
endfunction

////////////////////
// Scoreboard

function automatic void record_word(input fifo_data_t word);
	model_queue.push_back(word);
endfunction

// Next word the DUT should hand out
function automatic fifo_data_t oldest_word();
	if (model_queue.size() == 0) begin
		$display("%s: the FIFO returned a word that was never written", current_test);
		error_count++;
		return '0;
	end
	return model_queue.pop_front();
endfunction

`endif

// File: testbench/tb_cross_clock_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module tb_cross_clock_fifo;

	import fifo_pkg::*;

	////////////////////
	// Run limits

	// Rough length of each test in rd_clk cycles
	localparam int RESET_CYCLES = 40;
	localparam int ORDER_CYCLES = 100;
	localparam int FULL_CYCLES = 240;
	localparam int UNDERFLOW_CYCLES = 20;
	localparam int STREAM_CYCLES = 320;

	// Hard stop at twice the sum
	localparam int CYCLE_LIMIT = 2 * (RESET_CYCLES + ORDER_CYCLES + FULL_CYCLES
		+ UNDERFLOW_CYCLES + STREAM_CYCLES);

	// Bound on one pointer crossing, in cycles of the polling clock
	localparam int SETTLE_CYCLES = 64;

	localparam int STREAM_WORDS = 64;

	////////////////////
	// DUT signals

	logic wr_clk;
	logic wr_reset;
	logic wr_en;
	fifo_data_t wr_data;
	logic wr_full;
	fifo_ptr_t wr_size;
	logic wr_overflow;

	logic rd_clk;
	logic rd_reset;
	logic rd_en;
	fifo_data_t rd_data;
	logic rd_empty;
	fifo_ptr_t rd_size;
	logic rd_underflow;

	// Bookkeeping
	int tests_run = 0;
	int tests_failed = 0;
	int cycle_count = 0;
	int overflow_count = 0;
	int underflow_count = 0;

	`include "tb_checks.svh"

	cross_clock_fifo UUT (
		.wr_clk(wr_clk),
		.wr_reset(wr_reset),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.wr_full(wr_full),
		.wr_size(wr_size),
		.wr_overflow(wr_overflow),
		.rd_clk(rd_clk),
		.rd_reset(rd_reset),
		.rd_en(rd_en),
		.rd_data(rd_data),
		.rd_empty(rd_empty),
		.rd_size(rd_size),
		.rd_underflow(rd_underflow)
	);

	////////////////////
	// Clocks and monitors

	// 10 ns read clock
	initial begin
		rd_clk = 1'b0;
		forever #5 rd_clk = ~rd_clk;
	end

	// 14 ns write clock
	initial begin
		wr_clk = 1'b0;
		forever #7 wr_clk = ~wr_clk;
	end

	// Pulse counters
	always @(negedge wr_clk) begin
		if (wr_overflow === 1'b1) begin
			overflow_count++;
		end
	end

	always @(negedge rd_clk) begin
		if (rd_underflow === 1'b1) begin
			underflow_count++;
		end
	end

	// Global watchdog
	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge rd_clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d rd_clk cycles", CYCLE_LIMIT);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	////////////////////
	// Settling waits

	task automatic await_not_empty();
		for (int i = 0; i < SETTLE_CYCLES; i++) begin
			@(negedge rd_clk);
			if (rd_empty === 1'b0) break;
		end
		if (rd_empty !== 1'b0) begin
			$display("%s: rd_empty never fell within %0d cycles", current_test, SETTLE_CYCLES);
			error_count++;
		end
	endtask

	task automatic await_fill(input fifo_ptr_t target);
		for (int i = 0; i < SETTLE_CYCLES; i++) begin
			@(negedge rd_clk);
			if (rd_size === target) break;
		end
		if (rd_size !== target) begin
			$display("%s: rd_size did not settle at %0d within %0d cycles",
				current_test, target, SETTLE_CYCLES);
			error_count++;
		end
	endtask

	task automatic await_space(input fifo_ptr_t target);
		for (int i = 0; i < SETTLE_CYCLES; i++) begin
			@(negedge wr_clk);
			if (wr_size === target) break;
		end
		if (wr_size !== target) begin
			$display("%s: wr_size did not settle at %0d within %0d cycles",
				current_test, target, SETTLE_CYCLES);
			error_count++;
		end
	endtask

	////////////////////
	// Word transfers

	// Full sampled between the drive edge and the DUT's sampling edge
	task automatic push_word(input fifo_data_t word, output logic accepted);
		@(posedge wr_clk);
		wr_en <= 1'b1;
		wr_data <= word;
		@(negedge wr_clk);
		accepted = !wr_full;
		@(posedge wr_clk);
		wr_en <= 1'b0;
		if (accepted) begin
			record_word(word);
		end
	endtask

	// Data checked one rd_clk after the accepting edge
	task automatic pop_word(output logic accepted);
		fifo_data_t expected;
		@(posedge rd_clk);
		rd_en <= 1'b1;
		@(negedge rd_clk);
		accepted = !rd_empty;
		@(posedge rd_clk);
		rd_en <= 1'b0;
		@(negedge rd_clk);
		if (accepted) begin
			expected = oldest_word();
			compare_data("rd_data", expected, rd_data);
		end
	endtask

	task automatic check_queue_drained();
		if (model_queue.size() != 0) begin
			$display("%s: %0d written words were never read back",
				current_test, model_queue.size());
			error_count++;
		end
	endtask

	task automatic report_test(input int errors_at_start);
		tests_run++;
		if (error_count == errors_at_start) begin
			$display("%s: ok", current_test);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", current_test, error_count - errors_at_start);
		end
	endtask

	////////////////////
	// Tests

	task automatic check_reset_state();
		int errors_at_start;
		errors_at_start = error_count;
		current_test = "reset_state";
		@(negedge rd_clk);
		compare_flag("rd_empty", 1'b1, rd_empty);
		compare_size("rd_size", '0, rd_size);
		compare_flag("rd_underflow", 1'b0, rd_underflow);
		@(negedge wr_clk);
		compare_flag("wr_full", 1'b0, wr_full);
		compare_size("wr_size", fifo_ptr_t'(FIFO_DEPTH), wr_size);
		compare_flag("wr_overflow", 1'b0, wr_overflow);
		// Idle while both synchronizers cycle
		repeat (20) @(negedge rd_clk);
		compare_flag("overflow pulse seen", 1'b0, overflow_count != 0);
		compare_flag("underflow pulse seen", 1'b0, underflow_count != 0);
		report_test(errors_at_start);
	endtask

	task automatic keep_order();
		int errors_at_start;
		logic ok;
		errors_at_start = error_count;
		current_test = "ordering";
		repeat (5) begin
			push_word(random_word(), ok);
			compare_flag("write accepted", 1'b1, ok);
		end
		await_not_empty();
		await_fill(fifo_ptr_t'(5));
		compare_size("rd_size", fifo_ptr_t'(5), rd_size);
		repeat (5) begin
			pop_word(ok);
			compare_flag("read accepted", 1'b1, ok);
		end
		compare_flag("rd_empty after drain", 1'b1, rd_empty);
		report_test(errors_at_start);
	endtask

	task automatic fill_and_overflow();
		int errors_at_start;
		fifo_data_t extra;
		logic ok;
		errors_at_start = error_count;
		current_test = "full_overflow";
		await_space(fifo_ptr_t'(FIFO_DEPTH));
		repeat (FIFO_DEPTH) begin
			push_word(random_word(), ok);
			compare_flag("write accepted", 1'b1, ok);
		end
		@(negedge wr_clk);
		compare_flag("wr_full", 1'b1, wr_full);
		compare_size("wr_size", '0, wr_size);

		// Extra write meets full and is dropped
		extra = random_word();
		@(posedge wr_clk);
		wr_en <= 1'b1;
		wr_data <= extra;
		@(negedge wr_clk);
		compare_flag("wr_overflow before", 1'b0, wr_overflow);
		@(posedge wr_clk);
		wr_en <= 1'b0;
		@(negedge wr_clk);
		compare_flag("wr_overflow pulse", 1'b1, wr_overflow);
		@(negedge wr_clk);
		compare_flag("wr_overflow after", 1'b0, wr_overflow);

		// Drain must return only the queued words
		await_fill(fifo_ptr_t'(FIFO_DEPTH));
		repeat (FIFO_DEPTH) begin
			pop_word(ok);
			compare_flag("read accepted", 1'b1, ok);
		end
		compare_flag("rd_empty after drain", 1'b1, rd_empty);
		check_queue_drained();
		report_test(errors_at_start);
	endtask

	task automatic read_when_empty();
		int errors_at_start;
		errors_at_start = error_count;
		current_test = "underflow";
		@(negedge rd_clk);
		compare_flag("rd_empty", 1'b1, rd_empty);
		@(posedge rd_clk);
		rd_en <= 1'b1;
		@(negedge rd_clk);
		compare_flag("rd_underflow before", 1'b0, rd_underflow);
		@(posedge rd_clk);
		rd_en <= 1'b0;
		@(negedge rd_clk);
		compare_flag("rd_underflow pulse", 1'b1, rd_underflow);
		@(negedge rd_clk);
		compare_flag("rd_underflow after", 1'b0, rd_underflow);
		compare_size("rd_size", '0, rd_size);
		report_test(errors_at_start);
	endtask

	task automatic stream_words();
		int errors_at_start;
		int overflow_start;
		int underflow_start;
		int written;
		int read_back;
		logic write_ok;
		logic read_ok;
		errors_at_start = error_count;
		current_test = "streaming";
		overflow_start = overflow_count;
		underflow_start = underflow_count;
		written = 0;
		read_back = 0;
		await_space(fifo_ptr_t'(FIFO_DEPTH));
		fork
			// Writer honors wr_full
			while (written < STREAM_WORDS) begin
				@(negedge wr_clk);
				if (!wr_full) begin
					push_word(random_word(), write_ok);
					compare_flag("write accepted", 1'b1, write_ok);
					if (write_ok) written++;
				end
			end
			// Reader honors rd_empty
			while (read_back < STREAM_WORDS) begin
				@(negedge rd_clk);
				if (!rd_empty) begin
					pop_word(read_ok);
					compare_flag("read accepted", 1'b1, read_ok);
					if (read_ok) read_back++;
				end
			end
		join
		// Idle FIFO settles back to empty
		await_fill('0);
		compare_size("rd_size at end", '0, rd_size);
		await_space(fifo_ptr_t'(FIFO_DEPTH));
		compare_size("wr_size at end", fifo_ptr_t'(FIFO_DEPTH), wr_size);
		compare_flag("overflow during stream", 1'b0, overflow_count != overflow_start);
		compare_flag("underflow during stream", 1'b0, underflow_count != underflow_start);
		check_queue_drained();
		report_test(errors_at_start);
	endtask

	////////////////////
	// Main sequence

	initial begin
		wr_reset = 1'b1;
		rd_reset = 1'b1;
		wr_en = 1'b0;
		rd_en = 1'b0;
		wr_data = '0;

		// Each reset held 8 cycles of its own clock
		fork
			begin
				repeat (8) @(posedge wr_clk);
				wr_reset <= 1'b0;
			end
			begin
				repeat (8) @(posedge rd_clk);
				rd_reset <= 1'b0;
			end
		join

		check_reset_state();
		keep_order();
		fill_and_overflow();
		read_when_empty();
		stream_words();

		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: design/cross_clock_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module cross_clock_fifo (
	// Write domain
	input wire wr_clk,
	input wire wr_reset,
	input wire wr_en,
	input wire fifo_pkg::fifo_data_t wr_data,
	output wire wr_full,
	output wire fifo_pkg::fifo_ptr_t wr_size,
	output wire wr_overflow,

	// Read domain
	input wire rd_clk,
	input wire rd_reset,
	input wire rd_en,
	output wire fifo_pkg::fifo_data_t rd_data,
	output wire rd_empty,
	output wire fifo_pkg::fifo_ptr_t rd_size,
	output wire rd_underflow
);

	import fifo_pkg::*;

	////////////////////
	// Internal nets

	// Memory ports
	logic mem_we;
	fifo_addr_t mem_waddr;
	logic mem_re;
	fifo_addr_t mem_raddr;

	// Write pointer crossing
	logic wr_push;
	logic wr_push_ack;
	fifo_ptr_t wr_snap;
	fifo_ptr_t rd_wr_ptr;

	// Read pointer crossing
	logic rd_push;
	logic rd_push_ack;
	fifo_ptr_t rd_snap;
	fifo_ptr_t wr_rd_ptr;

	////////////////////
	// Storage

	dual_port_ram ram (
		.wr_clk(wr_clk),
		.mem_we(mem_we),
		.mem_waddr(mem_waddr),
		.wr_data(wr_data),
		.rd_clk(rd_clk),
		.mem_re(mem_re),
		.mem_raddr(mem_raddr),
		.rd_data(rd_data)
	);

	////////////////////
	// Write domain

	fifo_write_port write_port (
		.wr_clk(wr_clk),
		.wr_reset(wr_reset),
		.wr_en(wr_en),
		.wr_rd_ptr(wr_rd_ptr),
		.push_ack(wr_push_ack),
		.wr_full(wr_full),
		.wr_size(wr_size),
		.wr_overflow(wr_overflow),
		.mem_we(mem_we),
		.mem_waddr(mem_waddr),
		.push(wr_push),
		.snap(wr_snap)
	);

	////////////////////
	// Read domain

	fifo_read_port read_port (
		.rd_clk(rd_clk),
		.rd_reset(rd_reset),
		.rd_en(rd_en),
		.rd_wr_ptr(rd_wr_ptr),
		.push_ack(rd_push_ack),
		.rd_empty(rd_empty),
		.rd_size(rd_size),
		.rd_underflow(rd_underflow),
		.mem_re(mem_re),
		.mem_raddr(mem_raddr),
		.push(rd_push),
		.snap(rd_snap)
	);

	////////////////////
	// Pointer synchronizers

	// Write pointer into the read domain
	register_synchronizer sync_wr_ptr (
		.src_clk(wr_clk),
		.src_reset(wr_reset),
		.push(wr_push),
		.snap(wr_snap),
		.ack(wr_push_ack),
		.dst_clk(rd_clk),
		.dst_reset(rd_reset),
		.remote_ptr(rd_wr_ptr)
	);

	// Read pointer into the write domain
	register_synchronizer sync_rd_ptr (
		.src_clk(rd_clk),
		.src_reset(rd_reset),
		.push(rd_push),
		.snap(rd_snap),
		.ack(rd_push_ack),
		.dst_clk(wr_clk),
		.dst_reset(wr_reset),
		.remote_ptr(wr_rd_ptr)
	);

endmodule

`default_nettype wire

// File: design/fifo_read_port.sv
`default_nettype none
`timescale 1ns/1ps

module fifo_read_port (
	input wire rd_clk,
	input wire rd_reset,

	// Reader strobe
	input wire rd_en,

	// Write pointer as last seen in this domain
	input wire fifo_pkg::fifo_ptr_t rd_wr_ptr,
	input wire push_ack,

	// Status
	output logic rd_empty,
	output fifo_pkg::fifo_ptr_t rd_size,
	output logic rd_underflow,

	// Memory read port
	output logic mem_re,
	output fifo_pkg::fifo_addr_t mem_raddr,

	// Snapshot to the synchronizer
	output logic push,
	output fifo_pkg::fifo_ptr_t snap
);

	import fifo_pkg::*;

	////////////////////
	// Pointer and flags

	fifo_ptr_t rd_ptr;

	// Snapshot in flight
	logic busy;
	logic push_next;

	// Equal pointers mean nothing to pop
	// Stays high until the write pointer catches up
	assign rd_empty = (rd_ptr == rd_wr_ptr);

	// Fill level
	// Wrap bit makes the difference exact up to DEPTH
	assign rd_size = rd_wr_ptr - rd_ptr;

	// Pop only when there is a word
	assign mem_re = rd_en && !rd_empty;
	assign mem_raddr = rd_ptr[FIFO_ADDR_BITS-1:0];

	// Next snapshot goes out right after the ack
	assign push_next = !busy || push_ack;

	////////////////////
	// Control

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			rd_ptr <= '0;
			rd_underflow <= 1'b0;
			push <= 1'b0;
			busy <= 1'b0;
		end else begin
			// Flag a read that met empty
			rd_underflow <= rd_en && rd_empty;

			// Advance with each accepted pop
			if (mem_re) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			// One snapshot in flight at a time
			push <= push_next;
			busy <= 1'b1;
		end
	end

	// Latest read pointer for the write side
	always_ff @(posedge rd_clk) begin
		if (push_next) begin
			snap <= rd_ptr;
		end
	end

endmodule

`default_nettype wire

// File: design/fifo_write_port.sv
`default_nettype none
`timescale 1ns/1ps

module fifo_write_port (
	input wire wr_clk,
	input wire wr_reset,

	// Writer strobe
	input wire wr_en,

	// Read pointer as last seen in this domain
	input wire fifo_pkg::fifo_ptr_t wr_rd_ptr,
	input wire push_ack,

	// Status
	output logic wr_full,
	output fifo_pkg::fifo_ptr_t wr_size,
	output logic wr_overflow,

	// Memory write port
	output logic mem_we,
	output fifo_pkg::fifo_addr_t mem_waddr,

	// Snapshot to the synchronizer
	output logic push,
	output fifo_pkg::fifo_ptr_t snap
);

	import fifo_pkg::*;

	////////////////////
	// Pointer and flags

	fifo_ptr_t wr_ptr;

	// Read pointer one lap ahead
	fifo_ptr_t full_ptr;

	// Snapshot in flight
	logic busy;
	logic push_next;

	// Wraps mod 2*DEPTH like the pointers
	assign full_ptr = wr_rd_ptr + fifo_ptr_t'(FIFO_DEPTH);

	// Conservative while the read pointer lags
	assign wr_full = (wr_ptr == full_ptr);

	// Free slots
	assign wr_size = full_ptr - wr_ptr;

	// Dropped writes never reach storage
	assign mem_we = wr_en && !wr_full;
	assign mem_waddr = wr_ptr[FIFO_ADDR_BITS-1:0];

	// Send again as soon as the last one lands
	assign push_next = !busy || push_ack;

	////////////////////
	// Control

	always_ff @(posedge wr_clk) begin
		if (wr_reset) begin
			wr_ptr <= '0;
			wr_overflow <= 1'b0;
			push <= 1'b0;
			busy <= 1'b0;
		end else begin
			// Flag a write that met full
			wr_overflow <= wr_en && wr_full;

			if (mem_we) begin
				wr_ptr <= wr_ptr + 1'b1;
			end

			// Pace the snapshots
			push <= push_next;
			busy <= 1'b1;
		end
	end

	// Held for the synchronizer until acked
	always_ff @(posedge wr_clk) begin
		if (push_next) begin
			snap <= wr_ptr;
		end
	end

endmodule

`default_nettype wire

// File: design/register_synchronizer.sv
`default_nettype none
`timescale 1ns/1ps

module register_synchronizer (
	// Source domain
	input wire src_clk,
	input wire src_reset,
	input wire push,
	input wire fifo_pkg::fifo_ptr_t snap,
	output logic ack,

	// Destination domain
	input wire dst_clk,
	input wire dst_reset,
	output fifo_pkg::fifo_ptr_t remote_ptr
);

	import fifo_pkg::*;

	////////////////////
	// Source side state

	sync_state_t src_state;

	// Value in flight
	// Stable from the request toggle until the ack
	fifo_ptr_t src_hold;

	// Request toggle
	logic src_req;

	// Echoed toggle coming back from the destination
	logic [1:0] src_ack_sync;

	////////////////////
	// Destination side state

	// Two sync stages plus one for edge detect
	logic [2:0] dst_req_sync;

	////////////////////
	// Source FSM

	always_ff @(posedge src_clk) begin
		if (src_reset) begin
			src_state <= SYNC_IDLE;
			src_req <= 1'b0;
			src_ack_sync <= 2'b00;
			ack <= 1'b0;
		end else begin
			// Bring the echo into this domain
			src_ack_sync <= {src_ack_sync[0], dst_req_sync[2]};

			// Ack is a single cycle strobe
			ack <= 1'b0;

			case (src_state)
				SYNC_IDLE: begin
					// New snapshot starts a request
					if (push) begin
						src_req <= ~src_req;
						src_state <= SYNC_WAIT_ACK;
					end
				end

				SYNC_WAIT_ACK: begin
					// Echo matches request once the far side has captured
					if (src_ack_sync[1] == src_req) begin
						ack <= 1'b1;
						src_state <= SYNC_IDLE;
					end
				end

				default: begin
					src_state <= SYNC_IDLE;
				end
			endcase
		end
	end

	// Capture the snapshot on an accepted push
	always_ff @(posedge src_clk) begin
		if (push && (src_state == SYNC_IDLE)) begin
			src_hold <= snap;
		end
	end

	////////////////////
	// Destination capture

	always_ff @(posedge dst_clk) begin
		if (dst_reset) begin
			dst_req_sync <= 3'b000;
			remote_ptr <= '0;
		end else begin
			dst_req_sync <= {dst_req_sync[1:0], src_req};

			// Any toggle edge means src_hold has settled
			if (dst_req_sync[2] != dst_req_sync[1]) begin
				remote_ptr <= src_hold;
			end
		end
	end

	// dst_req_sync[2] flips on the capture cycle
	// It doubles as the echoed toggle sent back to the source

endmodule

`default_nettype wire

// File: design/dual_port_ram.sv
`default_nettype none
`timescale 1ns/1ps

module dual_port_ram (
	// Write port
	input wire wr_clk,
	input wire mem_we,
	input wire fifo_pkg::fifo_addr_t mem_waddr,
	input wire fifo_pkg::fifo_data_t wr_data,

	// Read port
	input wire rd_clk,
	input wire mem_re,
	input wire fifo_pkg::fifo_addr_t mem_raddr,
	output fifo_pkg::fifo_data_t rd_data
);

	import fifo_pkg::*;

	////////////////////
	// Storage

	// One word per FIFO slot
	fifo_data_t mem [FIFO_DEPTH];

	////////////////////
	// Write side

	// Only accepted words arrive here
	always_ff @(posedge wr_clk) begin
		if (mem_we) begin
			mem[mem_waddr] <= wr_data;
		end
	end

	////////////////////
	// Read side

	// Output register
	// Loads only on a pop so the word holds between reads
	always_ff @(posedge rd_clk) begin
		if (mem_re) begin
			rd_data <= mem[mem_raddr];
		end
	end

	// Read and write slots never collide
	// The pointers keep a popped slot apart from the one being filled

endmodule

`default_nettype wire

// File: design/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

	////////////////////
	// Geometry

	// Bits per data word
	localparam int FIFO_WIDTH = 16;

	// Words of storage
	localparam int FIFO_DEPTH = 16;

	// Address bits for the storage array
	localparam int FIFO_ADDR_BITS = $clog2(FIFO_DEPTH);

	////////////////////
	// Vector types

	typedef logic [FIFO_WIDTH-1:0] fifo_data_t;
	typedef logic [FIFO_ADDR_BITS-1:0] fifo_addr_t;

	// Address plus one wrap bit, also wide enough for a 0 to DEPTH count
	typedef logic [FIFO_ADDR_BITS:0] fifo_ptr_t;

	// Source side of the pointer synchronizer
	typedef enum logic {
		SYNC_IDLE,
		SYNC_WAIT_ACK
	} sync_state_t;

endpackage

`default_nettype wire
